// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// Width of instructions, addresses and bus data.
	parameter int WORD_BITS = 32;

	// Stored in place of the two always-zero address bits of a valid tag.
	parameter logic [1:0] TAG_VALID_BITS = 2'b01;

	typedef enum logic [1:0] {
		INITIALIZE = 2'd0,
		IDLE       = 2'd1,
		LOOKUP     = 2'd2,
		FILL       = 2'd3
	} icache_state_e;

	// States of the APB fill master.
	typedef enum logic [1:0] {
		APB_IDLE   = 2'd0,
		APB_SETUP  = 2'd1,
		APB_ACCESS = 2'd2
	} apb_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_bram #(
	parameter int INDEX_BITS = 6
) (
	input wire i_clock,
	input wire i_write,
	input wire [INDEX_BITS-1:0] i_index,
	input wire [2*fetch_pkg::WORD_BITS-1:0] i_wdata,
	output logic [2*fetch_pkg::WORD_BITS-1:0] o_rdata
);

	localparam int DEPTH = 1 << INDEX_BITS;

	// Upper word is the instruction, lower word the tag.
	logic [2*fetch_pkg::WORD_BITS-1:0] mem [DEPTH];

	// Registered read; a write returns the new entry on the same index.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_index];
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_pc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_sequencer #(
	parameter logic [fetch_pkg::WORD_BITS-1:0] RESET_PC = 32'h0000_0100
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_deliver,
	input wire i_redirect,
	input wire [fetch_pkg::WORD_BITS-1:0] i_redirect_pc,
	output logic [fetch_pkg::WORD_BITS-1:0] o_pc,
	output logic [fetch_pkg::WORD_BITS-1:0] o_next_pc
);

	logic [fetch_pkg::WORD_BITS-1:0] pc_plus_4;

	assign pc_plus_4 = o_pc + fetch_pkg::WORD_BITS'(4);

	// Redirect wins over sequential advance.
	always_comb begin
		if (i_redirect) begin
			o_next_pc = i_redirect_pc;
		end else if (i_deliver) begin
			o_next_pc = pc_plus_4;
		end else begin
			o_next_pc = o_pc;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_pc <= RESET_PC;
		end else begin
			o_pc <= o_next_pc;
		end
	end

	// Redirect targets come from downstream and must be word addresses.
	a_pc_aligned: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_pc[1:0] == 2'b00
	) else $error("fetch PC %h is not word aligned", o_pc);

endmodule

`default_nettype wire

// ==== hw/icache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lookup #(
	parameter int INDEX_BITS = 6
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_stall,
	input wire [fetch_pkg::WORD_BITS-1:0] i_pc,
	input wire [fetch_pkg::WORD_BITS-1:0] i_next_pc,
	input wire [2*fetch_pkg::WORD_BITS-1:0] i_ram_rdata,
	input wire i_fill_done,
	input wire [fetch_pkg::WORD_BITS-1:0] i_fill_data,
	input wire i_fill_error,
	output logic o_ram_write,
	output logic [INDEX_BITS-1:0] o_ram_index,
	output logic [2*fetch_pkg::WORD_BITS-1:0] o_ram_wdata,
	output logic o_fill_request,
	output logic [fetch_pkg::WORD_BITS-1:0] o_fill_address,
	output logic o_deliver,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr_pc,
	output logic o_instr_valid,
	output logic o_instr_error
);

	localparam int W = fetch_pkg::WORD_BITS;

	fetch_pkg::icache_state_e state;
	fetch_pkg::icache_state_e state_next;

	// Top bit set means every entry has been cleared.
	logic [INDEX_BITS:0] clear_count;
	logic [W-1:0] fill_address;
	logic [W-1:0] pc_tag;
	logic hit;
	logic fill_match;
	logic can_accept;
	logic [W-1:0] deliver_data;
	logic deliver_error;

	assign pc_tag = {i_pc[W-1:2], fetch_pkg::TAG_VALID_BITS};
	assign hit = (i_ram_rdata[W-1:0] == pc_tag);
	assign fill_match = (fill_address == i_pc);

	// The output register is free, or its word leaves this cycle.
	assign can_accept = !i_stall || !o_instr_valid;

	always_comb begin
		state_next = state;
		o_ram_write = 1'b0;
		o_ram_index = i_next_pc[INDEX_BITS+1:2];
		o_ram_wdata = {i_fill_data, fill_address[W-1:2], fetch_pkg::TAG_VALID_BITS};
		o_fill_request = 1'b0;
		o_fill_address = i_pc;
		o_deliver = 1'b0;
		deliver_data = i_ram_rdata[2*W-1:W];
		deliver_error = 1'b0;

		case (state)
			fetch_pkg::INITIALIZE: begin
				if (clear_count[INDEX_BITS]) begin
					// RAM is now reading the entry of the first PC.
					state_next = fetch_pkg::LOOKUP;
				end else begin
					o_ram_write = 1'b1;
					o_ram_index = clear_count[INDEX_BITS-1:0];
					o_ram_wdata = '0;
				end
			end

			fetch_pkg::IDLE: begin
				state_next = fetch_pkg::LOOKUP;
			end

			fetch_pkg::LOOKUP: begin
				if (hit) begin
					o_deliver = can_accept;
				end else begin
					o_fill_request = 1'b1;
					state_next = fetch_pkg::FILL;
				end
			end

			fetch_pkg::FILL: begin
				o_ram_index = fill_address[INDEX_BITS+1:2];
				o_fill_address = fill_address;
				o_fill_request = !i_fill_done;
				deliver_data = i_fill_data;
				deliver_error = i_fill_error;
				if (i_fill_done) begin
					// Error responses are never cached.
					o_ram_write = !i_fill_error;
					// After a redirect the word is stale and only cached.
					o_deliver = fill_match && can_accept;
					// RAM was busy with the fill, so read again.
					state_next = fetch_pkg::IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::INITIALIZE;
			clear_count <= '0;
		end else begin
			state <= state_next;
			if (state == fetch_pkg::INITIALIZE && !clear_count[INDEX_BITS]) begin
				clear_count <= clear_count + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::LOOKUP && !hit) begin
			fill_address <= i_pc;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_instr_valid <= 1'b0;
		end else if (can_accept) begin
			o_instr_valid <= o_deliver;
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_deliver) begin
			o_instr <= deliver_data;
			o_instr_pc <= i_pc;
			o_instr_error <= deliver_error;
		end
	end

	// Request and address hold across the fill handshake.
	a_fill_request_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_fill_request && !i_fill_done |=>
			(o_fill_request || i_fill_done) && $stable(o_fill_address)
	) else $error("fill request dropped or changed before done");

	a_no_valid_in_init: assert property (
		@(posedge i_clock) disable iff (i_reset)
		state == fetch_pkg::INITIALIZE |=> !o_instr_valid
	) else $error("instruction presented while the cache clears");

endmodule

`default_nettype wire

// ==== hw/apb_fill_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_fill_master (
	input wire i_clock,
	input wire i_reset,
	input wire i_fill_request,
	input wire [fetch_pkg::WORD_BITS-1:0] i_fill_address,
	input wire i_pready,
	input wire [fetch_pkg::WORD_BITS-1:0] i_prdata,
	input wire i_pslverr,
	output logic o_fill_done,
	output logic [fetch_pkg::WORD_BITS-1:0] o_fill_data,
	output logic o_fill_error,
	output logic o_psel,
	output logic o_penable,
	output logic [fetch_pkg::WORD_BITS-1:0] o_paddr,
	output logic o_pwrite
);

	fetch_pkg::apb_state_e state;

	assign o_psel = (state != fetch_pkg::APB_IDLE);
	assign o_penable = (state == fetch_pkg::APB_ACCESS);

	// Instruction fetch only reads.
	assign o_pwrite = 1'b0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::APB_IDLE;
			o_fill_done <= 1'b0;
		end else begin
			o_fill_done <= 1'b0;
			case (state)
				fetch_pkg::APB_IDLE: begin
					if (i_fill_request) begin
						state <= fetch_pkg::APB_SETUP;
					end
				end

				fetch_pkg::APB_SETUP: begin
					state <= fetch_pkg::APB_ACCESS;
				end

				fetch_pkg::APB_ACCESS: begin
					if (i_pready) begin
						o_fill_done <= 1'b1;
						state <= fetch_pkg::APB_IDLE;
					end
				end

				default: begin
					state <= fetch_pkg::APB_IDLE;
				end
			endcase
		end
	end

	// Address is taken once per transfer.
	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::APB_IDLE && i_fill_request) begin
			o_paddr <= i_fill_address;
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::APB_ACCESS && i_pready) begin
			o_fill_data <= i_prdata;
			o_fill_error <= i_pslverr;
		end
	end

	// The held request keeps PADDR on one address for the whole transfer.
	a_paddr_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_psel |-> i_fill_request && o_paddr == i_fill_address
	) else $error("PADDR left the requested fill address during an APB transfer");

endmodule

`default_nettype wire

// ==== hw/fetch_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_top #(
	parameter int INDEX_BITS = 6,
	parameter logic [fetch_pkg::WORD_BITS-1:0] RESET_PC = 32'h0000_0100
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_stall,
	input wire i_redirect,
	input wire [fetch_pkg::WORD_BITS-1:0] i_redirect_pc,
	output wire [fetch_pkg::WORD_BITS-1:0] o_instr,
	output wire [fetch_pkg::WORD_BITS-1:0] o_instr_pc,
	output wire o_instr_valid,
	output wire o_instr_error,
	output wire o_psel,
	output wire o_penable,
	output wire [fetch_pkg::WORD_BITS-1:0] o_paddr,
	output wire o_pwrite,
	input wire i_pready,
	input wire [fetch_pkg::WORD_BITS-1:0] i_prdata,
	input wire i_pslverr
);

	localparam int W = fetch_pkg::WORD_BITS;

	wire [W-1:0] pc;
	wire [W-1:0] next_pc;
	wire deliver;
	wire ram_write;
	wire [INDEX_BITS-1:0] ram_index;
	wire [2*W-1:0] ram_wdata;
	wire [2*W-1:0] ram_rdata;
	wire fill_request;
	wire [W-1:0] fill_address;
	wire fill_done;
	wire [W-1:0] fill_data;
	wire fill_error;

	fetch_pc_sequencer #(
		.RESET_PC(RESET_PC)
	) u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_deliver(deliver),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.o_pc(pc),
		.o_next_pc(next_pc)
	);

	icache_lookup #(
		.INDEX_BITS(INDEX_BITS)
	) u_lookup (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_pc(pc),
		.i_next_pc(next_pc),
		.i_ram_rdata(ram_rdata),
		.i_fill_done(fill_done),
		.i_fill_data(fill_data),
		.i_fill_error(fill_error),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.o_fill_request(fill_request),
		.o_fill_address(fill_address),
		.o_deliver(deliver),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc),
		.o_instr_valid(o_instr_valid),
		.o_instr_error(o_instr_error)
	);

	icache_bram #(
		.INDEX_BITS(INDEX_BITS)
	) u_bram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	apb_fill_master u_fill (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fill_request(fill_request),
		.i_fill_address(fill_address),
		.i_pready(i_pready),
		.i_prdata(i_prdata),
		.i_pslverr(i_pslverr),
		.o_fill_done(fill_done),
		.o_fill_data(fill_data),
		.o_fill_error(fill_error),
		.o_psel(o_psel),
		.o_penable(o_penable),
		.o_paddr(o_paddr),
		.o_pwrite(o_pwrite)
	);

endmodule

`default_nettype wire

// ==== bench/apb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_memory_model #(
	parameter logic [31:0] SEED = 32'h0000_0001,
	parameter logic [31:0] DATA_XOR = 32'h0000_0000,
	parameter logic [31:0] ERROR_LOW = 32'h0000_0000,
	parameter logic [31:0] ERROR_HIGH = 32'h0000_0000,
	parameter int MAX_WAIT = 3
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_psel,
	input wire i_penable,
	input wire [31:0] i_paddr,
	output logic o_pready,
	output logic [31:0] o_prdata,
	output logic o_pslverr
);

	int unsigned wait_left;

	// Ready is registered, so every transfer sees at least one wait state.
	initial begin
		void'($urandom(SEED));
		wait_left = 0;
		o_pready <= 1'b0;
		o_prdata <= '0;
		o_pslverr <= 1'b0;
		forever begin
			@(posedge i_clock);
			if (i_reset || o_pready) begin
				o_pready <= 1'b0;
				o_pslverr <= 1'b0;
			end else if (i_psel && !i_penable) begin
				wait_left = $urandom_range(MAX_WAIT, 0);
			end else if (i_psel && i_penable) begin
				if (wait_left == 0) begin
					o_pready <= 1'b1;
					o_prdata <= i_paddr ^ DATA_XOR;
					o_pslverr <= (i_paddr >= ERROR_LOW) && (i_paddr <= ERROR_HIGH);
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

	localparam int INDEX_BITS = 6;
	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam logic [31:0] DATA_XOR = 32'hA5C3_0000;
	localparam logic [31:0] ERROR_LOW = 32'h0000_0800;
	localparam logic [31:0] ERROR_HIGH = 32'h0000_08FF;
	localparam logic [31:0] SEED = 32'h514a_a972;
	localparam logic [31:0] LOOP_END = 32'h0000_014C;
	localparam logic [31:0] MISS_TARGET = 32'h0000_0400;
	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int INIT_CYCLES = (1 << INDEX_BITS) + 1;
	// All tests together stay below this many fetches of worst-case length.
	localparam int FETCH_COUNT = 80;
	localparam int WORST_FETCH_CYCLES = 16;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + INIT_CYCLES + FETCH_COUNT * WORST_FETCH_CYCLES) * PERIOD;

	logic clock = 1'b0;
	logic reset;
	logic stall;
	logic redirect;
	logic [31:0] redirect_pc;
	wire [31:0] instr;
	wire [31:0] instr_pc;
	wire instr_valid;
	wire instr_error;
	wire psel;
	wire penable;
	wire [31:0] paddr;
	wire pwrite;
	wire pready;
	wire [31:0] prdata;
	wire pslverr;
	wire consume;

	// Reference model state.
	logic [31:0] last_pc;
	logic [31:0] last_target;
	logic [31:0] miss_target;
	logic [31:0] error_paddr;
	logic miss_redirect;
	logic loop_armed;
	logic [4:0] loop_left;
	int init_cycles;
	int errors = 0;
	int errors_before = 0;
	int tests_done = 0;
	string test_name = "reset and initialization";

	assign consume = instr_valid && !stall;

	always #(PERIOD / 2) clock = !clock;

	fetch_unit_top #(
		.INDEX_BITS(INDEX_BITS),
		.RESET_PC(RESET_PC)
	) dut0 (
		.i_clock(clock),
		.i_reset(reset),
		.i_stall(stall),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.o_instr(instr),
		.o_instr_pc(instr_pc),
		.o_instr_valid(instr_valid),
		.o_instr_error(instr_error),
		.o_psel(psel),
		.o_penable(penable),
		.o_paddr(paddr),
		.o_pwrite(pwrite),
		.i_pready(pready),
		.i_prdata(prdata),
		.i_pslverr(pslverr)
	);

	apb_memory_model #(
		.SEED(SEED),
		.DATA_XOR(DATA_XOR),
		.ERROR_LOW(ERROR_LOW),
		.ERROR_HIGH(ERROR_HIGH)
	) memory0 (
		.i_clock(clock),
		.i_reset(reset),
		.i_psel(psel),
		.i_penable(penable),
		.i_paddr(paddr),
		.o_pready(pready),
		.o_prdata(prdata),
		.o_pslverr(pslverr)
	);

	function automatic logic [31:0] memory_word(input logic [31:0] address);
		return address ^ DATA_XOR;
	endfunction

	function automatic logic in_error_range(input logic [31:0] address);
		return (address >= ERROR_LOW) && (address <= ERROR_HIGH);
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string text);
		$display("ERROR in %s: %s", test_name, text);
		errors++;
	endtask

	// Returns on the edge that takes the word with this PC.
	task automatic wait_for_fetch(input logic [31:0] pc);
		do begin
			@(negedge clock);
		end while (!(consume && instr_pc == pc));
		@(posedge clock);
	endtask

	task automatic redirect_to(input logic [31:0] pc);
		redirect <= 1'b1;
		redirect_pc <= pc;
		@(posedge clock);
		redirect <= 1'b0;
	endtask

	task automatic finish_test(input string next_name);
		$display("%s finished with %0d errors", test_name, errors - errors_before);
		errors_before = errors;
		tests_done++;
		test_name = next_name;
	endtask

	always @(posedge clock) begin
		if (reset) begin
			init_cycles <= 0;
			last_pc <= RESET_PC - 32'd4;
			last_target <= RESET_PC;
			miss_redirect <= 1'b0;
			loop_left <= '0;
		end else begin
			if (init_cycles < INIT_CYCLES) begin
				init_cycles <= init_cycles + 1;
			end
			if (consume) begin
				last_pc <= instr_pc;
				miss_redirect <= 1'b0;
			end
			if (redirect) begin
				last_target <= redirect_pc;
			end
			// A redirect while the bus is busy must drop the fill word.
			if (redirect && psel) begin
				miss_redirect <= 1'b1;
				miss_target <= redirect_pc;
			end
			if (consume && loop_armed && instr_pc == RESET_PC) begin
				loop_left <= 5'd15;
			end else if (consume && loop_left != 0) begin
				loop_left <= loop_left - 1'b1;
			end
		end
		if (psel && penable && pready && pslverr) begin
			error_paddr <= paddr;
		end
	end

	a_init_quiet: assert property (@(posedge clock) disable iff (reset)
		init_cycles < INIT_CYCLES |-> !instr_valid && !psel)
		else report_problem("word or bus transfer while the cache clears");

	a_pc_order: assert property (@(posedge clock) disable iff (reset)
		consume |-> instr_pc == last_pc + 32'd4 || instr_pc == last_target)
		else report_mismatch("PC", $sampled(last_pc) + 32'd4, $sampled(instr_pc));

	a_word_rule: assert property (@(posedge clock) disable iff (reset)
		instr_valid && !instr_error |-> instr == memory_word(instr_pc))
		else report_mismatch("word", memory_word($sampled(instr_pc)), $sampled(instr));

	a_error_flag: assert property (@(posedge clock) disable iff (reset)
		instr_valid |-> instr_error == in_error_range(instr_pc))
		else report_mismatch("error flag", in_error_range($sampled(instr_pc)),
			$sampled(instr_error));

	a_error_fetched: assert property (@(posedge clock) disable iff (reset)
		instr_valid && instr_error |-> error_paddr == instr_pc)
		else report_mismatch("error address", $sampled(instr_pc), $sampled(error_paddr));

	a_hit_stream: assert property (@(posedge clock) disable iff (reset)
		loop_left != 0 |-> instr_valid && !psel)
		else report_problem("cached loop missed a cycle or used the bus");

	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		instr_valid && stall |=> instr_valid && $stable(instr) && $stable(instr_pc)
			&& $stable(instr_error))
		else report_problem("presented word changed during a stall");

	a_redirect_target: assert property (@(posedge clock) disable iff (reset)
		miss_redirect && instr_valid |-> instr_pc == miss_target)
		else report_mismatch("PC after redirect", $sampled(miss_target), $sampled(instr_pc));

	a_setup_access: assert property (@(posedge clock) disable iff (reset)
		psel && !penable |=> psel && penable)
		else report_problem("APB setup phase not followed by an access phase");

	a_penable_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(penable) |-> $past(psel))
		else report_problem("PENABLE rose without a setup cycle");

	a_read_only: assert property (@(posedge clock) disable iff (reset) !pwrite)
		else report_problem("PWRITE went high");

	initial begin
		reset <= 1'b1;
		stall <= 1'b0;
		redirect <= 1'b0;
		redirect_pc <= '0;
		loop_armed <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		wait_for_fetch(RESET_PC);
		finish_test("sequential stream");

		wait_for_fetch(LOOP_END);
		finish_test("hits after a loop");

		// Jump back over the 16 words that are still cached.
		loop_armed <= 1'b1;
		redirect_to(RESET_PC);
		wait_for_fetch(RESET_PC + 32'h3C);
		loop_armed <= 1'b0;
		finish_test("stall");

		repeat (3) begin
			do begin
				@(negedge clock);
			end while (!instr_valid);
			@(posedge clock);
			stall <= 1'b1;
			repeat (12) @(posedge clock);
			stall <= 1'b0;
		end
		finish_test("redirect during a miss");

		do begin
			@(negedge clock);
		end while (!(psel && !penable));
		@(posedge clock);
		redirect_to(MISS_TARGET);
		wait_for_fetch(MISS_TARGET);
		finish_test("bus error and APB rules");

		wait_for_fetch(MISS_TARGET + 32'd4);
		redirect_to(ERROR_LOW);
		wait_for_fetch(ERROR_LOW);
		redirect_to(ERROR_LOW);
		wait_for_fetch(ERROR_LOW);
		wait_for_fetch(ERROR_LOW + 32'd8);
		finish_test("done");

		repeat (4) @(posedge clock);
		$display("%0d tests run, %0d checks failed", tests_done, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired in %s, the fetch unit stopped delivering words", test_name);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/fetch_pkg.sv
hw/icache_bram.sv
hw/fetch_pc_sequencer.sv
hw/icache_lookup.sv
hw/apb_fill_master.sv
hw/fetch_unit_top.sv
bench/apb_memory_model.sv
bench/fetch_unit_tb.sv
